// File: source/rx_dma_pkg.sv
// rx dma shared definitions
package rx_dma_pkg;

    localparam int dma_word_w = 64;
    localparam int tsf_w = 64;
    localparam int iq_w = 16;
    localparam int rssi_w = 11;
    localparam int gpio_w = 8;
    localparam int sym_cnt_w = 14;
    localparam int timeout_w = 13;
    localparam int count_top_w = 15;

    // clock cycles per unit of the interrupt delay setting
    localparam int intr_count_scale = 2;

    localparam int rst_hold_cycles = 8;
    localparam int rst_cnt_w = $clog2(rst_hold_cycles);

    typedef enum logic [1:0] {
        mode_framed   = 2'd0,
        mode_raw_fcs  = 2'd1,
        mode_raw_sig  = 2'd2,
        mode_raw_trig = 2'd3
    } capture_mode_t;

    typedef struct packed {
        logic [7:0]        rate;
        logic [15:0]       len;
        logic              sgi;
        logic [rssi_w-1:0] rssi;
        logic [gpio_w-1:0] gpio;
    } rx_sig_info_t;

    typedef struct packed {
        capture_mode_t          mode;
        // 0 decoder words, 1 loopback iq
        logic                   src_sel;
        logic                   recover_en;
        logic [timeout_w-1:0]   timeout_top;
        logic [count_top_w-1:0] count_top;
    } rx_cfg_t;

    // second header word as seen by the host driver
    typedef struct packed {
        logic [9:0]        pad_hi;
        logic              sgi;
        logic              rate_hi;
        logic [3:0]        rate_lo;
        logic [15:0]       len;
        logic [7:0]        pad_mid;
        logic [gpio_w-1:0] gpio;
        logic [4:0]        pad_lo;
        logic [rssi_w-1:0] rssi;
    } rx_info_word_t;

    typedef union packed {
        logic [dma_word_w-1:0] raw;
        rx_info_word_t         info;
    } dma_hdr_word_u;

endpackage

// File: source/rx_hdr_capture.sv
// rx header capture
`timescale 1ns/10ps

module rx_hdr_capture (
    input  logic                               clk,
    input  logic                               rstn,
    input  logic                               sig_valid,
    input  rx_dma_pkg::rx_sig_info_t           sig_info,
    input  logic [rx_dma_pkg::tsf_w-1:0]       tsf_runtime,
    output logic [rx_dma_pkg::tsf_w-1:0]       tsf_lock,
    output rx_dma_pkg::rx_sig_info_t           info_lock,
    output logic [rx_dma_pkg::sym_cnt_w-1:0]   num_sym
);
    import rx_dma_pkg::*;

    logic [sym_cnt_w-1:0] len_words;
    logic [sym_cnt_w-1:0] len_rem;

    // bytes to 8-byte words, rounded up
    assign len_words = sym_cnt_w'(sig_info.len[15:3]);
    assign len_rem = sym_cnt_w'(|sig_info.len[2:0]);

    // header values frozen at start of packet
    always_ff @(posedge clk) begin
        if (sig_valid) begin
            tsf_lock <= tsf_runtime;
            info_lock <= sig_info;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            num_sym <= '0;
        end else if (sig_valid) begin
            // plus two header words
            num_sym <= len_words + len_rem + sym_cnt_w'(2);
        end
    end

endmodule

// File: source/rx_dma_framer.sv
// rx dma packet framer
`timescale 1ns/10ps

module rx_dma_framer (
    input  logic                               clk,
    input  logic                               rstn,
    input  logic                               start_pkt,
    input  logic                               ht_unsupport,
    input  logic [rx_dma_pkg::tsf_w-1:0]       tsf_lock,
    input  rx_dma_pkg::rx_sig_info_t           info_lock,
    input  logic [rx_dma_pkg::sym_cnt_w-1:0]   num_sym,
    input  logic [rx_dma_pkg::dma_word_w-1:0]  acc_data,
    input  logic                               acc_valid,
    input  logic                               block_valid,
    input  logic                               block,
    input  logic                               m_axis_tlast,
    input  logic                               tsf_pulse_1m,
    input  logic                               recover_en,
    input  logic [rx_dma_pkg::timeout_w-1:0]   timeout_top,
    output rx_dma_pkg::dma_hdr_word_u          framed_data,
    output logic                               framed_valid,
    output logic                               framed_start,
    output logic                               sn_plus_one,
    output logic                               m_axis_rst,
    output logic                               tlast_auto_recover,
    output logic [rx_dma_pkg::sym_cnt_w-1:0]   num_dma_symbol
);
    import rx_dma_pkg::*;

    typedef enum logic [2:0] {
        st_idle        = 3'd0,
        st_hdr0        = 3'd1,
        st_hdr1        = 3'd2,
        st_wait_filter = 3'd3,
        st_wait_tlast  = 3'd4,
        st_rst_hold    = 3'd5
    } state_t;

    state_t               state;
    logic [timeout_w-1:0] timer;
    logic [timeout_w-1:0] timer_next;
    logic [rst_cnt_w-1:0] rst_cnt;
    rx_info_word_t        info_word;
    logic                 waiting;
    logic                 timed_out;
    logic                 hold_recover;
    logic                 hold_block;

    assign waiting = (state == st_wait_filter) || (state == st_wait_tlast);
    assign timed_out = recover_en && (timer > timeout_top);
    assign hold_recover = waiting && timed_out;
    assign hold_block = (state == st_wait_filter) && !timed_out && block_valid && block;

    // timeout wins over a decision in the same cycle
    assign sn_plus_one = (state == st_wait_filter) && !timed_out && block_valid && !block;

    // 1 us ticks, held at the top so a disabled recovery cannot wrap
    assign timer_next = (tsf_pulse_1m && (timer != '1)) ? timer + 1'b1 : timer;

    always_comb begin
        info_word = '0;
        info_word.sgi = info_lock.sgi;
        info_word.rate_hi = info_lock.rate[7];
        info_word.rate_lo = info_lock.rate[3:0];
        info_word.len = info_lock.len;
        info_word.gpio = info_lock.gpio;
        info_word.rssi = info_lock.rssi;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= st_idle;
            timer <= '0;
            rst_cnt <= '0;
            framed_data <= '0;
            framed_valid <= 1'b0;
            framed_start <= 1'b0;
            m_axis_rst <= 1'b0;
            tlast_auto_recover <= 1'b0;
            num_dma_symbol <= '0;
        end else begin
            case (state)
                st_idle: begin
                    timer <= '0;
                    rst_cnt <= '0;
                    framed_data <= '0;
                    framed_valid <= 1'b0;
                    framed_start <= 1'b0;
                    m_axis_rst <= 1'b0;
                    tlast_auto_recover <= 1'b0;
                    if (start_pkt && !ht_unsupport) begin
                        state <= st_hdr0;
                    end
                end
                st_hdr0: begin
                    framed_data.raw <= tsf_lock;
                    framed_valid <= 1'b1;
                    num_dma_symbol <= num_sym;
                    state <= st_hdr1;
                end
                st_hdr1: begin
                    framed_data.info <= info_word;
                    state <= st_wait_filter;
                end
                st_wait_filter: begin
                    framed_data.raw <= acc_data;
                    framed_valid <= acc_valid;
                    if (sn_plus_one) begin
                        timer <= '0;
                        framed_start <= 1'b1;
                        state <= st_wait_tlast;
                    end else begin
                        timer <= timer_next;
                    end
                end
                st_wait_tlast: begin
                    framed_data.raw <= acc_data;
                    framed_valid <= acc_valid;
                    framed_start <= 1'b0;
                    timer <= timer_next;
                    if (m_axis_tlast) begin
                        state <= st_idle;
                    end
                end
                st_rst_hold: begin
                    tlast_auto_recover <= 1'b0;
                    framed_data <= '0;
                    framed_valid <= 1'b0;
                    num_dma_symbol <= '0;
                    rst_cnt <= rst_cnt + 1'b1;
                    if (rst_cnt == rst_cnt_w'(rst_hold_cycles - 1)) begin
                        m_axis_rst <= 1'b0;
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase

            // abort path, overrides the per-state updates above
            if (hold_recover || hold_block) begin
                state <= st_rst_hold;
                m_axis_rst <= 1'b1;
                tlast_auto_recover <= hold_recover;
                framed_data <= '0;
                framed_valid <= 1'b0;
                num_dma_symbol <= '0;
            end
        end
    end

endmodule

// File: source/rx_stream_mux.sv
// rx stream source select
`timescale 1ns/10ps

module rx_stream_mux (
    input  rx_dma_pkg::capture_mode_t          mode,
    input  logic                               src_sel,
    input  logic                               fcs_valid,
    input  logic                               sig_valid,
    input  logic                               ext_trigger,
    input  logic                               framed_start,
    input  rx_dma_pkg::dma_hdr_word_u          framed_data,
    input  logic                               framed_valid,
    input  logic [rx_dma_pkg::dma_word_w-1:0]  acc_data,
    input  logic                               acc_valid,
    input  logic [2*rx_dma_pkg::iq_w-1:0]      iq,
    input  logic                               iq_valid,
    output logic                               stream_start,
    output logic [rx_dma_pkg::dma_word_w-1:0]  stream_data,
    output logic                               stream_valid
);
    import rx_dma_pkg::*;

    always_comb begin
        case (mode)
            mode_framed:   stream_start = framed_start;
            mode_raw_fcs:  stream_start = fcs_valid;
            mode_raw_sig:  stream_start = sig_valid;
            mode_raw_trig: stream_start = ext_trigger;
            default:       stream_start = 1'b0;
        endcase
    end

    always_comb begin
        if (mode == mode_framed) begin
            stream_data = framed_data.raw;
            stream_valid = framed_valid;
        end else if (src_sel) begin
            // loopback iq in the low half
            stream_data = {{(dma_word_w - 2*iq_w){1'b0}}, iq};
            stream_valid = iq_valid;
        end else begin
            stream_data = acc_data;
            stream_valid = acc_valid;
        end
    end

endmodule

// File: source/rx_intr_delay.sv
// rx packet interrupt delay
`timescale 1ns/10ps

module rx_intr_delay (
    input  logic                               clk,
    input  logic                               rstn,
    input  logic                               s2mm_intr,
    input  logic [rx_dma_pkg::count_top_w-1:0] count_top,
    output logic                               rx_pkt_intr
);
    import rx_dma_pkg::*;

    logic                   s2mm_intr_d;
    logic                   intr_rise;
    logic [count_top_w:0]   limit;
    logic [count_top_w:0]   limit_p1;
    logic [count_top_w:0]   count;

    assign intr_rise = s2mm_intr && !s2mm_intr_d;

    // quasi-static setting, two register stages
    always_ff @(posedge clk) begin
        limit <= {1'b0, count_top} * (count_top_w + 1)'(intr_count_scale);
        limit_p1 <= limit + 1'b1;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            s2mm_intr_d <= 1'b0;
            // parked past any limit so nothing fires before the first edge
            count <= '1;
            rx_pkt_intr <= 1'b0;
        end else begin
            s2mm_intr_d <= s2mm_intr;
            if (intr_rise) begin
                count <= '0;
                rx_pkt_intr <= 1'b0;
            end else begin
                if (count < limit_p1) begin
                    count <= count + 1'b1;
                end
                rx_pkt_intr <= (count == limit);
            end
        end
    end

endmodule

// File: source/rx_dma_top.sv
// rx dma stream top level
`timescale 1ns/10ps

module rx_dma_top (
    input  logic                               clk,
    input  logic                               rstn,
    input  rx_dma_pkg::rx_cfg_t                cfg,
    input  logic                               sig_valid,
    input  rx_dma_pkg::rx_sig_info_t           sig_info,
    input  logic                               ht_unsupport,
    input  logic                               fcs_valid,
    input  logic [rx_dma_pkg::dma_word_w-1:0]  acc_data,
    input  logic                               acc_valid,
    input  logic [2*rx_dma_pkg::iq_w-1:0]      iq,
    input  logic                               iq_valid,
    input  logic [rx_dma_pkg::tsf_w-1:0]       tsf_runtime,
    input  logic                               tsf_pulse_1m,
    input  logic                               block_valid,
    input  logic                               block,
    input  logic                               m_axis_tlast,
    input  logic                               s2mm_intr,
    input  logic                               ext_trigger,
    output logic                               stream_start,
    output logic [rx_dma_pkg::dma_word_w-1:0]  stream_data,
    output logic                               stream_valid,
    output logic                               m_axis_rst,
    output logic                               tlast_auto_recover,
    output logic                               rx_pkt_sn_plus_one,
    output logic [rx_dma_pkg::sym_cnt_w-1:0]   num_dma_symbol,
    output logic                               rx_pkt_intr
);
    import rx_dma_pkg::*;

    logic [tsf_w-1:0]     tsf_lock;
    rx_sig_info_t         info_lock;
    logic [sym_cnt_w-1:0] num_sym;
    dma_hdr_word_u        framed_data;
    logic                 framed_valid;
    logic                 framed_start;

    rx_hdr_capture u_capture (
        .clk         (clk),
        .rstn        (rstn),
        .sig_valid   (sig_valid),
        .sig_info    (sig_info),
        .tsf_runtime (tsf_runtime),
        .tsf_lock    (tsf_lock),
        .info_lock   (info_lock),
        .num_sym     (num_sym)
    );

    rx_dma_framer u_framer (
        .clk                (clk),
        .rstn               (rstn),
        .start_pkt          (sig_valid),
        .ht_unsupport       (ht_unsupport),
        .tsf_lock           (tsf_lock),
        .info_lock          (info_lock),
        .num_sym            (num_sym),
        .acc_data           (acc_data),
        .acc_valid          (acc_valid),
        .block_valid        (block_valid),
        .block              (block),
        .m_axis_tlast       (m_axis_tlast),
        .tsf_pulse_1m       (tsf_pulse_1m),
        .recover_en         (cfg.recover_en),
        .timeout_top        (cfg.timeout_top),
        .framed_data        (framed_data),
        .framed_valid       (framed_valid),
        .framed_start       (framed_start),
        .sn_plus_one        (rx_pkt_sn_plus_one),
        .m_axis_rst         (m_axis_rst),
        .tlast_auto_recover (tlast_auto_recover),
        .num_dma_symbol     (num_dma_symbol)
    );

    rx_stream_mux u_stream_mux (
        .mode         (cfg.mode),
        .src_sel      (cfg.src_sel),
        .fcs_valid    (fcs_valid),
        .sig_valid    (sig_valid),
        .ext_trigger  (ext_trigger),
        .framed_start (framed_start),
        .framed_data  (framed_data),
        .framed_valid (framed_valid),
        .acc_data     (acc_data),
        .acc_valid    (acc_valid),
        .iq           (iq),
        .iq_valid     (iq_valid),
        .stream_start (stream_start),
        .stream_data  (stream_data),
        .stream_valid (stream_valid)
    );

    rx_intr_delay u_intr_delay (
        .clk         (clk),
        .rstn        (rstn),
        .s2mm_intr   (s2mm_intr),
        .count_top   (cfg.count_top),
        .rx_pkt_intr (rx_pkt_intr)
    );

endmodule

// File: verification/rx_dma_checker.sv
// rx dma control assertions
`timescale 1ns/10ps

module rx_dma_checker (
    input logic                      clk,
    input logic                      rstn,
    input rx_dma_pkg::capture_mode_t mode,
    input logic                      m_axis_rst,
    input logic                      tlast_auto_recover,
    input logic                      stream_start,
    input logic                      rx_pkt_intr
);
    import rx_dma_pkg::*;

    int hold_len;
    int fail_cnt = 0;

    // length of the current reset run
    always_ff @(posedge clk) begin
        if (!rstn || !m_axis_rst) begin
            hold_len <= 0;
        end else begin
            hold_len <= hold_len + 1;
        end
    end

    a_rst_len: assert property (@(posedge clk) disable iff (!rstn)
        hold_len <= rst_hold_cycles)
        else begin
            fail_cnt++;
            $error("m_axis_rst held longer than the reset hold");
        end

    a_recover_pulse: assert property (@(posedge clk) disable iff (!rstn)
        tlast_auto_recover |=> (!tlast_auto_recover && m_axis_rst))
        else begin
            fail_cnt++;
            $error("tlast_auto_recover not a single pulse followed by reset");
        end

    a_start_pulse: assert property (@(posedge clk) disable iff (!rstn)
        (mode == mode_framed && stream_start) |=> !stream_start)
        else begin
            fail_cnt++;
            $error("framed stream_start longer than one cycle");
        end

    a_intr_pulse: assert property (@(posedge clk) disable iff (!rstn)
        rx_pkt_intr |=> !rx_pkt_intr)
        else begin
            fail_cnt++;
            $error("rx_pkt_intr longer than one cycle");
        end

endmodule

bind rx_dma_top rx_dma_checker chk0 (
    .clk                (clk),
    .rstn               (rstn),
    .mode               (cfg.mode),
    .m_axis_rst         (m_axis_rst),
    .tlast_auto_recover (tlast_auto_recover),
    .stream_start       (stream_start),
    .rx_pkt_intr        (rx_pkt_intr)
);

// File: verification/rx_dma_tb.sv
// rx dma stream testbench
`timescale 1ns/10ps

module rx_dma_tb;
    import rx_dma_pkg::*;

    localparam int n_pkts = 8;
    localparam int max_words = 8;
    localparam int max_cycles = n_pkts * (max_words + 40) + 2 * 80 + 4 * 12 + 2 * 60 + 100;

    logic clk = 1'b0;
    logic rstn;
    rx_cfg_t cfg;
    logic sig_valid;
    rx_sig_info_t sig_info;
    logic ht_unsupport;
    logic fcs_valid;
    logic [dma_word_w-1:0] acc_data;
    logic acc_valid;
    logic [2*iq_w-1:0] iq;
    logic iq_valid;
    logic [tsf_w-1:0] tsf_runtime;
    logic tsf_pulse_1m;
    logic block_valid;
    logic block;
    logic m_axis_tlast;
    logic s2mm_intr;
    logic ext_trigger;
    logic stream_start;
    logic [dma_word_w-1:0] stream_data;
    logic stream_valid;
    logic m_axis_rst;
    logic tlast_auto_recover;
    logic rx_pkt_sn_plus_one;
    logic [sym_cnt_w-1:0] num_dma_symbol;
    logic rx_pkt_intr;

    integer seed = 32'hac55;
    int errors = 0;
    int cycles = 0;
    int start_cnt = 0;
    int rst_cyc = 0;
    int recov_cnt = 0;
    int valid_cnt = 0;
    logic sn_prev = 1'b0;
    logic [dma_word_w-1:0] expq[$];

    rx_dma_top dut0 (.*);

    always #50 clk = ~clk;

    // second header word as the host driver decodes it
    function automatic logic [63:0] info_word_ref(input rx_sig_info_t info);
        return {10'b0, info.sgi, info.rate[7], info.rate[3:0], info.len, 8'b0,
                info.gpio, 5'b0, info.rssi};
    endfunction

    function automatic int num_sym_ref(input int len);
        return (len + 7) / 8 + 2;
    endfunction

    // framed stream compare and event counting
    always @(negedge clk) begin
        logic [dma_word_w-1:0] exp_word;
        if (rstn && cfg.mode == mode_framed) begin
            if (stream_valid) begin
                valid_cnt++;
                assert (expq.size() > 0) else begin
                    errors++;
                    $display("valid word seen with no word expected");
                end
                if (expq.size() > 0) begin
                    exp_word = expq.pop_front();
                    assert (stream_data == exp_word) else begin
                        errors++;
                        $display("Fail stream_data: got %h expected %h", stream_data, exp_word);
                    end
                end
            end
            if (stream_start) begin
                start_cnt++;
                assert (sn_prev) else begin
                    errors++;
                    $display("stream_start without a filter pass before it");
                end
            end
            if (m_axis_rst) begin
                rst_cyc++;
                assert (num_dma_symbol == '0) else begin
                    errors++;
                    $display("Fail num_dma_symbol: got %h expected %h", num_dma_symbol, 0);
                end
            end
            if (tlast_auto_recover) begin
                recov_cnt++;
            end
            sn_prev = rx_pkt_sn_plus_one;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > max_cycles) begin
            $display("run stopped at the cycle limit, the DUT did not respond");
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic pass_and_tlast();
        @(posedge clk);
        block_valid <= 1'b1;
        block <= 1'b0;
        @(posedge clk);
        block_valid <= 1'b0;
        repeat (2) @(posedge clk);
        m_axis_tlast <= 1'b1;
        @(posedge clk);
        m_axis_tlast <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    // decision 0 pass, 1 block, 2 none
    task automatic send_packet(input int len, input int decision, input bit ht);
        rx_sig_info_t info;
        logic [tsf_w-1:0] tsf;
        logic [dma_word_w-1:0] word;
        int nwords;
        int starts0;
        int rsts0;
        int vcnt0;
        info.rate = $random(seed);
        info.len = len[15:0];
        info.sgi = $random(seed);
        info.rssi = $random(seed);
        info.gpio = $random(seed);
        tsf = {$random(seed), $random(seed)};
        nwords = (len + 7) / 8;
        starts0 = start_cnt;
        rsts0 = rst_cyc;
        vcnt0 = valid_cnt;
        if (!ht) begin
            expq.push_back(tsf);
            expq.push_back(info_word_ref(info));
        end
        @(posedge clk);
        sig_valid <= 1'b1;
        sig_info <= info;
        tsf_runtime <= tsf;
        ht_unsupport <= ht;
        @(posedge clk);
        sig_valid <= 1'b0;
        ht_unsupport <= 1'b0;
        // live values move on, only the copy taken at sig_valid is right
        tsf_runtime <= ~tsf;
        sig_info <= ~info;
        if (ht) begin
            repeat (8) @(posedge clk);
            assert (valid_cnt == vcnt0) else begin
                errors++;
                $display("ignored packet produced valid words");
            end
        end else begin
            @(posedge clk);
            for (int i = 0; i < nwords; i++) begin
                @(posedge clk);
                word = {$random(seed), $random(seed)};
                acc_data <= word;
                acc_valid <= 1'b1;
                expq.push_back(word);
            end
            @(posedge clk);
            acc_valid <= 1'b0;
            // last payload word has already left the stream here
            @(posedge clk);
            @(negedge clk);
            assert (num_dma_symbol == sym_cnt_w'(num_sym_ref(len))) else begin
                errors++;
                $display("Fail num_dma_symbol: got %h expected %h", num_dma_symbol,
                         num_sym_ref(len));
            end
            assert (expq.size() == 0) else begin
                errors++;
                $display("packet words missing from the stream");
            end
            if (decision == 0) begin
                pass_and_tlast();
                assert (start_cnt == starts0 + 1 && rst_cyc == rsts0) else begin
                    errors++;
                    $display("passed packet did not give exactly one stream_start");
                end
            end else if (decision == 1) begin
                @(posedge clk);
                block_valid <= 1'b1;
                block <= 1'b1;
                @(posedge clk);
                block_valid <= 1'b0;
                block <= 1'b0;
                repeat (12) @(posedge clk);
                assert (start_cnt == starts0) else begin
                    errors++;
                    $display("blocked packet raised stream_start");
                end
                assert (rst_cyc == rsts0 + rst_hold_cycles) else begin
                    errors++;
                    $display("Fail m_axis_rst cycles: got %h expected %h", rst_cyc - rsts0,
                             rst_hold_cycles);
                end
            end
        end
    endtask

    task automatic run_timeout(input bit en);
        int recov0;
        int rst0;
        @(posedge clk);
        cfg.recover_en <= en;
        cfg.timeout_top <= 13'd3;
        recov0 = recov_cnt;
        rst0 = rst_cyc;
        send_packet(16, 2, 1'b0);
        for (int i = 0; i < 30 && recov_cnt == recov0; i++) begin
            @(posedge clk);
            tsf_pulse_1m <= 1'b1;
        end
        @(posedge clk);
        tsf_pulse_1m <= 1'b0;
        if (en) begin
            repeat (12) @(posedge clk);
            assert (recov_cnt == recov0 + 1 && rst_cyc == rst0 + rst_hold_cycles) else begin
                errors++;
                $display("timeout did not give one recovery pulse and a reset hold");
            end
        end else begin
            assert (recov_cnt == recov0 && rst_cyc == rst0) else begin
                errors++;
                $display("recovery appeared while it was disabled");
            end
            pass_and_tlast();
        end
        cfg.recover_en <= 1'b1;
        cfg.timeout_top <= 13'd200;
    endtask

    task automatic run_raw(input capture_mode_t mode, input bit src);
        logic [31:0] r;
        logic exp_start;
        logic [dma_word_w-1:0] exp_data;
        logic exp_valid;
        @(posedge clk);
        cfg.mode <= mode;
        cfg.src_sel <= src;
        // keep the framer idle while sig_valid toggles
        ht_unsupport <= 1'b1;
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            r = $random(seed);
            fcs_valid <= r[0];
            sig_valid <= r[1];
            ext_trigger <= r[2];
            acc_valid <= r[3];
            iq_valid <= r[4];
            acc_data <= {$random(seed), $random(seed)};
            iq <= $random(seed);
            @(negedge clk);
            exp_start = (mode == mode_raw_fcs) ? fcs_valid :
                        (mode == mode_raw_sig) ? sig_valid : ext_trigger;
            exp_data = src ? {32'b0, iq} : acc_data;
            exp_valid = src ? iq_valid : acc_valid;
            assert (stream_start == exp_start) else begin
                errors++;
                $display("Fail stream_start: got %h expected %h", stream_start, exp_start);
            end
            assert (stream_data == exp_data) else begin
                errors++;
                $display("Fail stream_data: got %h expected %h", stream_data, exp_data);
            end
            assert (stream_valid == exp_valid) else begin
                errors++;
                $display("Fail stream_valid: got %h expected %h", stream_valid, exp_valid);
            end
        end
        @(posedge clk);
        fcs_valid <= 1'b0;
        sig_valid <= 1'b0;
        ext_trigger <= 1'b0;
        acc_valid <= 1'b0;
        iq_valid <= 1'b0;
        ht_unsupport <= 1'b0;
        cfg.mode <= mode_framed;
        cfg.src_sel <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    task automatic run_intr(input int top);
        int hits;
        int fire_at;
        hits = 0;
        fire_at = -1;
        @(posedge clk);
        cfg.count_top <= top[count_top_w-1:0];
        repeat (4) @(posedge clk);
        s2mm_intr <= 1'b1;
        @(posedge clk);
        s2mm_intr <= 1'b0;
        for (int k = 1; k <= intr_count_scale * top + 10; k++) begin
            @(posedge clk);
            @(negedge clk);
            if (rx_pkt_intr) begin
                hits++;
                fire_at = k;
            end
        end
        assert (hits == 1 && fire_at == intr_count_scale * top + 1) else begin
            errors++;
            $display("Fail rx_pkt_intr delay: got %h expected %h", fire_at,
                     intr_count_scale * top + 1);
        end
    endtask

    initial begin
        rstn = 1'b0;
        cfg = '{mode: mode_framed, src_sel: 1'b0, recover_en: 1'b1,
                timeout_top: 13'd200, count_top: 15'd5};
        sig_valid = 1'b0;
        sig_info = '0;
        ht_unsupport = 1'b0;
        fcs_valid = 1'b0;
        acc_data = '0;
        acc_valid = 1'b0;
        iq = '0;
        iq_valid = 1'b0;
        tsf_runtime = '0;
        tsf_pulse_1m = 1'b0;
        block_valid = 1'b0;
        block = 1'b0;
        m_axis_tlast = 1'b0;
        s2mm_intr = 1'b0;
        ext_trigger = 1'b0;
        repeat (4) @(posedge clk);
        rstn <= 1'b1;
        repeat (2) @(posedge clk);
        for (int p = 0; p < 3; p++) begin
            send_packet(1 + ($unsigned($random(seed)) % (8 * max_words)), 0, 1'b0);
        end
        send_packet(37, 1, 1'b0);
        send_packet(8, 0, 1'b0);
        send_packet(20, 0, 1'b1);
        run_timeout(1'b1);
        run_timeout(1'b0);
        run_raw(mode_raw_fcs, 1'b0);
        run_raw(mode_raw_sig, 1'b1);
        run_raw(mode_raw_trig, 1'b0);
        run_raw(mode_raw_trig, 1'b1);
        run_intr(5);
        run_intr(3);
        $display("errors: %0d assertion failures: %0d", errors, dut0.chk0.fail_cnt);
        if (errors == 0 && dut0.chk0.fail_cnt == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: filelist.f
source/rx_dma_pkg.sv
source/rx_hdr_capture.sv
source/rx_dma_framer.sv
source/rx_stream_mux.sv
source/rx_intr_delay.sv
source/rx_dma_top.sv
verification/rx_dma_checker.sv
verification/rx_dma_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the rx dma testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module rx_dma_tb \
    -o rx_dma_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/rx_dma_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST PASSED" sim.log; then
    exit 0
fi
exit 1
